// ==== common/oq_stats_pkg.sv ====
`default_nettype none

package oq_stats_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int data_width = 32;
  localparam int addr_width = 8;

  typedef logic [data_width-1:0] word_t;
  typedef logic [addr_width-1:0] reg_addr_t;

  // ----------------------------------------
  // register map, word addresses
  // ----------------------------------------
  localparam reg_addr_t ctrl_addr  = 8'd0;   // bit 0 clears counters
  localparam reg_addr_t ipd_addr   = 8'd1;
  localparam reg_addr_t stats_base = 8'd16;  // + 8*queue + field
  localparam reg_addr_t rcv_base   = 8'd64;  // + entry
  localparam int        stats_per_queue = 8;

  // strobes from the packet buffer of one queue
  typedef struct packed {
    logic  stored;
    logic  removed;
    logic  dropped;
    word_t bytes_removed;  // valid with removed
  } q_event_t;

  // field order matches the read offsets 0..7
  typedef struct packed {
    word_t pkt_stored;
    word_t bytes_stored;
    word_t pkt_removed;
    word_t bytes_removed;
    word_t pkt_dropped;
    word_t bytes_dropped;
    word_t pkt_in_queue;
    word_t bytes_in_queue;
  } q_stats_t;

endpackage

`default_nettype wire

// ==== hdl/usec_timer.sv ====
`default_nettype none

module usec_timer #(
  parameter int usec_div = 125
) (
  input  wire                 axi_aclk,
  input  wire                 axi_resetn,
  output oq_stats_pkg::word_t usec_time
);

  localparam int               div_w    = (usec_div > 1) ? $clog2(usec_div) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(usec_div - 1);

  logic [div_w-1:0] div_cnt;
  logic             tick;

  // divider, tick follows the last count by one cycle
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (div_cnt == div_last) begin
      div_cnt <= '0;
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt + 1'b1;
      tick    <= 1'b0;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      usec_time <= '0;
    end else if (tick) begin
      usec_time <= usec_time + 1'b1;  // free running, wraps
    end
  end

endmodule

`default_nettype wire

// ==== stats/queue_stats.sv ====
`default_nettype none

module queue_stats (
  input  wire                      axi_aclk,
  input  wire                      axi_resetn,
  input  wire                      clear_cntrs,
  input  wire oq_stats_pkg::q_event_t q_event,
  input  wire oq_stats_pkg::word_t bytes_stored,   // shared by all queues
  input  wire oq_stats_pkg::word_t bytes_dropped,  // shared by all queues
  output oq_stats_pkg::q_stats_t   stats
);

  // ----------------------------------------
  // event counters
  // ----------------------------------------
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn || clear_cntrs) begin
      stats.pkt_stored    <= '0;
      stats.bytes_stored  <= '0;
      stats.pkt_removed   <= '0;
      stats.bytes_removed <= '0;
      stats.pkt_dropped   <= '0;
      stats.bytes_dropped <= '0;
    end else begin
      if (q_event.stored) begin
        stats.pkt_stored   <= stats.pkt_stored + 1'b1;
        stats.bytes_stored <= stats.bytes_stored + bytes_stored;
      end
      if (q_event.removed) begin
        stats.pkt_removed   <= stats.pkt_removed + 1'b1;
        stats.bytes_removed <= stats.bytes_removed + q_event.bytes_removed;
      end
      if (q_event.dropped) begin
        stats.pkt_dropped   <= stats.pkt_dropped + 1'b1;
        stats.bytes_dropped <= stats.bytes_dropped + bytes_dropped;
      end
    end
  end

  // ----------------------------------------
  // occupancy, one cycle behind the counters
  // ----------------------------------------
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      stats.pkt_in_queue   <= '0;
      stats.bytes_in_queue <= '0;
    end else begin
      // modulo 2^32, stays right across wrap
      stats.pkt_in_queue   <= stats.pkt_stored - stats.pkt_removed;
      stats.bytes_in_queue <= stats.bytes_stored - stats.bytes_removed;
    end
  end

endmodule

`default_nettype wire

// ==== stats/rcv_time_log.sv ====
`default_nettype none

module rcv_time_log #(
  parameter int num_rcv_time = 8
) (
  input  wire                                      axi_aclk,
  input  wire                                      axi_resetn,
  input  wire                                      pkt_stored,
  input  wire oq_stats_pkg::word_t                 usec_time,
  output oq_stats_pkg::word_t [num_rcv_time-1:0]   entries
);

  localparam int               idx_w    = (num_rcv_time > 1) ? $clog2(num_rcv_time) : 1;
  localparam logic [idx_w-1:0] idx_last = idx_w'(num_rcv_time - 1);

  logic [idx_w-1:0] wr_idx;  // next slot, oldest once full

  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      wr_idx <= '0;
    end else if (pkt_stored) begin
      wr_idx <= (wr_idx == idx_last) ? '0 : wr_idx + 1'b1;
    end
  end

  // ring of timestamps
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      entries <= '0;
    end else if (pkt_stored) begin
      entries[wr_idx] <= usec_time;
    end
  end

endmodule

`default_nettype wire

// ==== regs/stats_regs.sv ====
`default_nettype none

module stats_regs #(
  parameter int num_queues   = 5,
  parameter int num_rcv_time = 8
) (
  input  wire                                         axi_aclk,
  input  wire                                         axi_resetn,
  input  wire oq_stats_pkg::reg_addr_t                reg_addr,
  input  wire                                         reg_wr,
  input  wire                                         reg_rd,
  input  wire oq_stats_pkg::word_t                    reg_wdata,
  output oq_stats_pkg::word_t                         reg_rdata,
  output logic                                        reg_rd_ack,
  output logic                                        clear_cntrs,
  output oq_stats_pkg::word_t                         ipd_value,
  input  wire oq_stats_pkg::q_stats_t [num_queues-1:0] all_stats,
  input  wire oq_stats_pkg::word_t [num_rcv_time-1:0] rcv_entries
);

  localparam int k_w  = $clog2(oq_stats_pkg::stats_per_queue);
  localparam int ri_w = (num_rcv_time > 1) ? $clog2(num_rcv_time) : 1;

  // window ends, exclusive
  localparam oq_stats_pkg::reg_addr_t stats_end =
    oq_stats_pkg::reg_addr_t'(oq_stats_pkg::stats_base +
                              oq_stats_pkg::stats_per_queue * num_queues);
  localparam oq_stats_pkg::reg_addr_t rcv_end =
    oq_stats_pkg::reg_addr_t'(oq_stats_pkg::rcv_base + num_rcv_time);

  oq_stats_pkg::reg_addr_t stats_off;
  oq_stats_pkg::reg_addr_t rcv_off;
  oq_stats_pkg::word_t     rd_word;

  // counter k of one queue, k in struct field order
  function automatic oq_stats_pkg::word_t field_word(
    input oq_stats_pkg::q_stats_t s,
    input logic [k_w-1:0]         k
  );
    case (k)
      0:       field_word = s.pkt_stored;
      1:       field_word = s.bytes_stored;
      2:       field_word = s.pkt_removed;
      3:       field_word = s.bytes_removed;
      4:       field_word = s.pkt_dropped;
      5:       field_word = s.bytes_dropped;
      6:       field_word = s.pkt_in_queue;
      default: field_word = s.bytes_in_queue;
    endcase
  endfunction

  // ----------------------------------------
  // writable registers
  // ----------------------------------------
  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      clear_cntrs <= 1'b0;
      ipd_value   <= '0;
    end else if (reg_wr) begin
      if (reg_addr == oq_stats_pkg::ctrl_addr) begin
        clear_cntrs <= reg_wdata[0];
      end
      if (reg_addr == oq_stats_pkg::ipd_addr) begin
        ipd_value <= reg_wdata;
      end
    end
  end

  // ----------------------------------------
  // read decode
  // ----------------------------------------
  always_comb begin
    stats_off = reg_addr - oq_stats_pkg::stats_base;
    rcv_off   = reg_addr - oq_stats_pkg::rcv_base;
    rd_word   = '0;  // unmapped
    if (reg_addr == oq_stats_pkg::ctrl_addr) begin
      rd_word[0] = clear_cntrs;
    end else if (reg_addr == oq_stats_pkg::ipd_addr) begin
      rd_word = ipd_value;
    end else if (reg_addr >= oq_stats_pkg::stats_base && reg_addr < stats_end) begin
      // upper offset bits pick the queue, lower bits the counter
      rd_word = field_word(all_stats[stats_off[oq_stats_pkg::addr_width-1:k_w]],
                           stats_off[k_w-1:0]);
    end else if (reg_addr >= oq_stats_pkg::rcv_base && reg_addr < rcv_end) begin
      rd_word = rcv_entries[rcv_off[ri_w-1:0]];
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_resetn) begin
      reg_rd_ack <= 1'b0;
    end else begin
      reg_rd_ack <= reg_rd;  // single cycle ack
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (reg_rd) begin
      reg_rdata <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/oq_stats_top.sv ====
`default_nettype none

module oq_stats_top #(
  parameter int num_queues   = 5,    // 4 ethernet + 1 dma
  parameter int usec_div     = 125,  // clocks per microsecond
  parameter int watch_queue  = 3,
  parameter int num_rcv_time = 8
) (
  input  wire                                         axi_aclk,
  input  wire                                         axi_resetn,

  // packet buffer strobes
  input  wire oq_stats_pkg::q_event_t [num_queues-1:0] q_events,
  input  wire oq_stats_pkg::word_t                    bytes_stored,
  input  wire oq_stats_pkg::word_t                    bytes_dropped,

  // register port
  input  wire oq_stats_pkg::reg_addr_t                reg_addr,
  input  wire                                         reg_wr,
  input  wire                                         reg_rd,
  input  wire oq_stats_pkg::word_t                    reg_wdata,
  output oq_stats_pkg::word_t                         reg_rdata,
  output logic                                        reg_rd_ack,

  output oq_stats_pkg::word_t                         ipd_value
);

  wire oq_stats_pkg::word_t                      usec_time;
  wire                                           clear_cntrs;
  wire oq_stats_pkg::q_stats_t [num_queues-1:0]  all_stats;
  wire oq_stats_pkg::word_t [num_rcv_time-1:0]   rcv_entries;

  // ----------------------------------------
  // microsecond time base
  // ----------------------------------------
  usec_timer #(
    .usec_div (usec_div)
  ) u_usec_timer (
    .axi_aclk   (axi_aclk),
    .axi_resetn (axi_resetn),
    .usec_time  (usec_time)
  );

  // ----------------------------------------
  // per-queue counters
  // ----------------------------------------
  for (genvar q = 0; q < num_queues; q++) begin : g_queue
    queue_stats u_queue_stats (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .clear_cntrs   (clear_cntrs),
      .q_event       (q_events[q]),
      .bytes_stored  (bytes_stored),
      .bytes_dropped (bytes_dropped),
      .stats         (all_stats[q])
    );
  end

  // arrival times of the watched queue only
  rcv_time_log #(
    .num_rcv_time (num_rcv_time)
  ) u_rcv_time_log (
    .axi_aclk   (axi_aclk),
    .axi_resetn (axi_resetn),
    .pkt_stored (q_events[watch_queue].stored),
    .usec_time  (usec_time),
    .entries    (rcv_entries)
  );

  stats_regs #(
    .num_queues   (num_queues),
    .num_rcv_time (num_rcv_time)
  ) u_stats_regs (
    .axi_aclk    (axi_aclk),
    .axi_resetn  (axi_resetn),
    .reg_addr    (reg_addr),
    .reg_wr      (reg_wr),
    .reg_rd      (reg_rd),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .reg_rd_ack  (reg_rd_ack),
    .clear_cntrs (clear_cntrs),
    .ipd_value   (ipd_value),
    .all_stats   (all_stats),
    .rcv_entries (rcv_entries)
  );

endmodule

`default_nettype wire

// ==== test/tb_oq_stats_tasks.svh ====
// ----------------------------------------
// checking and reference model
// ----------------------------------------
task automatic check_value(input string name, input oq_stats_pkg::word_t got,
                           input oq_stats_pkg::word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("[FAIL] %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic zero_model();
  int q;
  for (q = 0; q < num_queues; q++) begin
    m_pkt_st[q] = '0;
    m_b_st[q]   = '0;
    m_pkt_rm[q] = '0;
    m_b_rm[q]   = '0;
    m_pkt_dr[q] = '0;
    m_b_dr[q]   = '0;
  end
endtask

function automatic oq_stats_pkg::word_t model_counter(input int q, input int k);
  case (k)
    0:       return m_pkt_st[q];
    1:       return m_b_st[q];
    2:       return m_pkt_rm[q];
    3:       return m_b_rm[q];
    4:       return m_pkt_dr[q];
    5:       return m_b_dr[q];
    6:       return m_pkt_st[q] - m_pkt_rm[q];
    default: return m_b_st[q] - m_b_rm[q];
  endcase
endfunction

function automatic oq_stats_pkg::reg_addr_t stats_addr(input int q, input int k);
  return oq_stats_pkg::reg_addr_t'(oq_stats_pkg::stats_base + 8 * q + k);
endfunction

function automatic oq_stats_pkg::reg_addr_t rcv_addr(input int i);
  return oq_stats_pkg::reg_addr_t'(oq_stats_pkg::rcv_base + i);
endfunction

// ----------------------------------------
// bus and event drivers
// ----------------------------------------
task automatic reg_write(input oq_stats_pkg::reg_addr_t addr, input oq_stats_pkg::word_t data);
  @(negedge axi_aclk);
  reg_addr  = addr;
  reg_wdata = data;
  reg_wr    = 1'b1;
  @(negedge axi_aclk);
  reg_wr = 1'b0;
endtask

task automatic reg_read(input oq_stats_pkg::reg_addr_t addr, output oq_stats_pkg::word_t data);
  int waited;
  waited = 0;
  @(negedge axi_aclk);
  reg_addr = addr;
  reg_rd   = 1'b1;
  @(negedge axi_aclk);
  reg_rd = 1'b0;
  while (!reg_rd_ack && waited < 4) begin
    @(negedge axi_aclk);
    waited++;
  end
  if (reg_rd_ack) begin
    data = reg_rdata;
  end else begin
    errors++;
    $display("read of address %0d got no acknowledge within 4 cycles", addr);
    data = 'x;
  end
endtask

task automatic read_and_check(input oq_stats_pkg::reg_addr_t addr,
                              input oq_stats_pkg::word_t exp, input string name);
  oq_stats_pkg::word_t got;
  reg_read(addr, got);
  check_value(name, got, exp);
endtask

// one cycle of strobes with the model kept in step
task automatic apply_events(input logic [4:0] st, input logic [4:0] rm, input logic [4:0] dr);
  oq_stats_pkg::word_t b_st;
  oq_stats_pkg::word_t b_dr;
  oq_stats_pkg::word_t b_rm;
  int                  q;
  b_st = $urandom_range(64, 1518);
  b_dr = $urandom_range(64, 1518);
  @(negedge axi_aclk);
  bytes_stored  = b_st;
  bytes_dropped = b_dr;
  for (q = 0; q < num_queues; q++) begin
    b_rm = $urandom_range(64, 1518);
    q_events[q].stored        = st[q];
    q_events[q].removed       = rm[q];
    q_events[q].dropped       = dr[q];
    q_events[q].bytes_removed = b_rm;
    if (!clear_held) begin
      if (st[q]) begin
        m_pkt_st[q] += 1;
        m_b_st[q]   += b_st;
      end
      if (rm[q]) begin
        m_pkt_rm[q] += 1;
        m_b_rm[q]   += b_rm;
      end
      if (dr[q]) begin
        m_pkt_dr[q] += 1;
        m_b_dr[q]   += b_dr;
      end
    end
  end
  if (st[watch_queue]) begin
    log_ts[log_idx] = oq_stats_pkg::word_t'(cyc / usec_div);
    log_idx = (log_idx + 1) % num_rcv_time;
  end
endtask

task automatic idle_events();
  @(negedge axi_aclk);
  q_events      = '0;
  bytes_stored  = '0;
  bytes_dropped = '0;
endtask

task automatic check_all_counters();
  int q;
  int k;
  for (q = 0; q < num_queues; q++) begin
    for (k = 0; k < oq_stats_pkg::stats_per_queue; k++) begin
      read_and_check(stats_addr(q, k), model_counter(q, k),
                     $sformatf("reg_rdata q%0d counter %0d", q, k));
    end
  end
endtask

task automatic check_log();
  oq_stats_pkg::word_t got;
  oq_stats_pkg::word_t exp;
  int                  i;
  for (i = 0; i < num_rcv_time; i++) begin
    reg_read(rcv_addr(i), got);
    exp = log_ts[i];
    if (got == exp || got == exp + 1 || got + 1 == exp) exp = got;  // one usec slack
    check_value($sformatf("reg_rdata rcv entry %0d", i), got, exp);
  end
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------
task automatic test_after_reset();
  int i;
  check_value("reg_rd_ack", oq_stats_pkg::word_t'(reg_rd_ack), '0);
  check_value("ipd_value", ipd_value, '0);
  read_and_check(oq_stats_pkg::ctrl_addr, '0, "reg_rdata ctrl");
  read_and_check(oq_stats_pkg::ipd_addr, '0, "reg_rdata ipd");
  check_all_counters();
  for (i = 0; i < num_rcv_time; i++) begin
    read_and_check(rcv_addr(i), '0, $sformatf("reg_rdata rcv entry %0d", i));
  end
endtask

task automatic test_rcv_log();
  int i;
  for (i = 0; i < 10; i++) begin
    apply_events(5'(1 << watch_queue), '0, '0);
    idle_events();
    repeat ($urandom_range(1, 25)) @(negedge axi_aclk);
  end
  check_log();  // entries 0 and 1 now hold captures 9 and 10
  apply_events(~5'(1 << watch_queue), '0, '0);
  idle_events();
  check_log();
endtask

task automatic test_counting();
  int n;
  for (n = 0; n < 200; n++) begin
    apply_events(5'($urandom), 5'($urandom), 5'($urandom));
  end
  idle_events();
  check_all_counters();
endtask

task automatic test_clear();
  logic [4:0] no_watch;
  int         i;
  no_watch = ~5'(1 << watch_queue);
  reg_write(oq_stats_pkg::ctrl_addr, 32'd1);
  clear_held = 1'b1;
  zero_model();
  check_all_counters();
  read_and_check(oq_stats_pkg::ctrl_addr, 32'd1, "reg_rdata ctrl");
  // held at zero
  for (i = 0; i < 20; i++) apply_events(5'($urandom) & no_watch, 5'($urandom), 5'($urandom));
  idle_events();
  check_all_counters();
  reg_write(oq_stats_pkg::ctrl_addr, 32'd0);
  clear_held = 1'b0;
  for (i = 0; i < 50; i++) apply_events(5'($urandom) & no_watch, 5'($urandom), 5'($urandom));
  idle_events();
  check_all_counters();
  check_log();  // clearing leaves the log alone
endtask

task automatic test_ipd_and_unmapped();
  oq_stats_pkg::reg_addr_t unmapped [6] = '{8'd2, 8'd15, 8'd56, 8'd63, 8'd72, 8'd255};
  oq_stats_pkg::word_t     ipd;
  int                      i;
  ipd = $urandom;
  reg_write(oq_stats_pkg::ipd_addr, ipd);
  read_and_check(oq_stats_pkg::ipd_addr, ipd, "reg_rdata ipd");
  check_value("ipd_value", ipd_value, ipd);
  for (i = 0; i < 6; i++) begin
    read_and_check(unmapped[i], '0, $sformatf("reg_rdata addr %0d", unmapped[i]));
    reg_write(unmapped[i], $urandom);
    read_and_check(unmapped[i], '0, $sformatf("reg_rdata addr %0d", unmapped[i]));
  end
  read_and_check(oq_stats_pkg::ipd_addr, ipd, "reg_rdata ipd");
  read_and_check(oq_stats_pkg::ctrl_addr, '0, "reg_rdata ctrl");
  check_value("ipd_value", ipd_value, ipd);
  check_all_counters();
  check_log();
endtask

// ==== test/tb_oq_stats.sv ====
`default_nettype none

module tb_oq_stats;

  localparam int num_queues   = 5;
  localparam int usec_div     = 10;
  localparam int watch_queue  = 3;
  localparam int num_rcv_time = 8;
  localparam int num_tests    = 5;

  logic                                    axi_aclk;
  logic                                    axi_resetn;
  oq_stats_pkg::q_event_t [num_queues-1:0] q_events;
  oq_stats_pkg::word_t                     bytes_stored;
  oq_stats_pkg::word_t                     bytes_dropped;
  oq_stats_pkg::reg_addr_t                 reg_addr;
  logic                                    reg_wr;
  logic                                    reg_rd;
  oq_stats_pkg::word_t                     reg_wdata;
  oq_stats_pkg::word_t                     reg_rdata;
  logic                                    reg_rd_ack;
  oq_stats_pkg::word_t                     ipd_value;

  // ----------------------------------------
  // scoreboard state
  // ----------------------------------------
  int   errors;
  int   checks;
  int   cyc = 0;     // clocks since reset release
  logic clear_held;  // counters held by control bit 0
  int   log_idx;

  oq_stats_pkg::word_t m_pkt_st [num_queues];
  oq_stats_pkg::word_t m_b_st   [num_queues];
  oq_stats_pkg::word_t m_pkt_rm [num_queues];
  oq_stats_pkg::word_t m_b_rm   [num_queues];
  oq_stats_pkg::word_t m_pkt_dr [num_queues];
  oq_stats_pkg::word_t m_b_dr   [num_queues];
  oq_stats_pkg::word_t log_ts   [num_rcv_time];  // expected usec per entry

  always begin
    #5 axi_aclk = ~axi_aclk;
  end

  always @(posedge axi_aclk) begin
    if (axi_resetn) cyc <= cyc + 1;
  end

  oq_stats_top #(
    .usec_div (usec_div)
  ) dut (
    .axi_aclk      (axi_aclk),
    .axi_resetn    (axi_resetn),
    .q_events      (q_events),
    .bytes_stored  (bytes_stored),
    .bytes_dropped (bytes_dropped),
    .reg_addr      (reg_addr),
    .reg_wr        (reg_wr),
    .reg_rd        (reg_rd),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .reg_rd_ack    (reg_rd_ack),
    .ipd_value     (ipd_value)
  );

  `include "tb_oq_stats_tasks.svh"

  initial begin
    #(num_tests * 20000);
    $display("watchdog expired before the test sequence finished");
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int i;
    void'($urandom(32'h012f8429));
    axi_aclk      = 1'b0;
    axi_resetn    = 1'b0;
    q_events      = '0;
    bytes_stored  = '0;
    bytes_dropped = '0;
    reg_addr      = '0;
    reg_wr        = 1'b0;
    reg_rd        = 1'b0;
    reg_wdata     = '0;
    errors        = 0;
    checks        = 0;
    clear_held    = 1'b0;
    log_idx       = 0;
    zero_model();
    for (i = 0; i < num_rcv_time; i++) log_ts[i] = '0;

    repeat (10) @(negedge axi_aclk);
    axi_resetn = 1'b1;

    test_after_reset();
    test_rcv_log();  // right after reset, log index still 0
    test_counting();
    test_clear();
    test_ipd_and_unmapped();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+test
common/oq_stats_pkg.sv
hdl/usec_timer.sv
stats/queue_stats.sv
stats/rcv_time_log.sv
regs/stats_regs.sv
hdl/oq_stats_top.sv
test/tb_oq_stats.sv

// ==== Makefile ====
TOP := tb_oq_stats

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "STATUS: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --top-module oq_stats_top \
		common/oq_stats_pkg.sv \
		hdl/usec_timer.sv \
		stats/queue_stats.sv \
		stats/rcv_time_log.sv \
		regs/stats_regs.sv \
		hdl/oq_stats_top.sv

clean:
	rm -rf obj_dir sim.log
